//--- logic/rv_pkg.sv
package rv_pkg;

    // datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // jump counter carried with every fetched word
    localparam int TAG_W      = 3;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    ////////////////////
    // base opcodes
    ////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // NOP also covers every unknown encoding
    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND, OR, XOR, LUI, LW, SW, BEQ, BNE, JAL
    } op_e;

    ////////////////////
    // instruction views
    ////////////////////
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // branches reuse this view, the B immediate is a reshuffle of it
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

    ////////////////////
    // stage bundles
    ////////////////////
    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      tag;
    } dec_exe_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  is_load;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    // ops that produce a register result
    function automatic logic writes_rd(op_e op);
        return op inside {ADD, SUB, AND, OR, XOR, LUI, LW, JAL};
    endfunction

endpackage

//--- logic/rv_regbank.sv
`timescale 1ns/1ps

module rv_regbank (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   rs2_i,
    input  rv_pkg::wb_t                     wb_i,
    input  logic [rv_pkg::XLEN-1:0]         mem_data_i,
    output logic [rv_pkg::XLEN-1:0]         rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]         rs2_data_o
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs_q [1:31];
    logic [rv_pkg::XLEN-1:0] wr_data;

    // load data arrives in the retire cycle itself
    assign wr_data = wb_i.is_load ? mem_data_i : wb_i.result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wr_data;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // execute already drops writes aimed at x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_i.we |-> wb_i.rd != '0);

endmodule

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        enable_i,
    input  rv_pkg::redirect_t           redirect_i,
    input  logic [rv_pkg::XLEN-1:0]     instruction_data_i,
    output logic [rv_pkg::XLEN-1:0]     instruction_address_o,
    output rv_pkg::instr_u              instruction_o,
    output logic [rv_pkg::XLEN-1:0]     pc_o,
    output logic [rv_pkg::TAG_W-1:0]    tag_o
);

    logic [rv_pkg::XLEN-1:0]  pc_q;
    logic [rv_pkg::TAG_W-1:0] tag_q;
    // pc and tag of the word now on instruction_data_i
    logic [rv_pkg::XLEN-1:0]  pc_d_q;
    logic [rv_pkg::TAG_W-1:0] tag_d_q;
    logic                     held_q;
    logic [rv_pkg::XLEN-1:0]  hold_buf_q;
    logic                     advance;

    assign advance = redirect_i.valid || enable_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= rv_pkg::RESET_PC;
            tag_q   <= '0;
            pc_d_q  <= rv_pkg::RESET_PC;
            // word seen right after reset is stale, give it a foreign tag
            tag_d_q <= '1;
            held_q  <= 1'b0;
        end else begin
            // redirect wins over enable
            if (redirect_i.valid) begin
                pc_q  <= redirect_i.target;
                tag_q <= tag_q + 1'b1;
            end else if (enable_i) begin
                pc_q  <= pc_q + rv_pkg::XLEN'(4);
            end
            if (advance) begin
                pc_d_q  <= pc_q;
                tag_d_q <= tag_q;
            end
            held_q <= !advance;
        end
    end

    // grab the word once, later cycles return the next address
    always_ff @(posedge clk) begin
        if (!advance && !held_q) begin
            hold_buf_q <= instruction_data_i;
        end
    end

    assign instruction_address_o = pc_q;
    assign instruction_o         = held_q ? hold_buf_q : instruction_data_i;
    assign pc_o                  = pc_d_q;
    assign tag_o                 = tag_d_q;

    // jump targets from execute must stay word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        instruction_address_o[1:0] == 2'b00);

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            stall_i,
    input  rv_pkg::instr_u                  instruction_i,
    input  logic [rv_pkg::XLEN-1:0]         pc_i,
    input  logic [rv_pkg::TAG_W-1:0]        tag_i,
    input  rv_pkg::redirect_t               redirect_i,
    input  rv_pkg::dec_exe_t                exe_i,
    input  rv_pkg::wb_t                     wb_i,
    input  logic [rv_pkg::XLEN-1:0]         rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]         rs2_data_i,
    output logic [rv_pkg::REG_ADDR_W-1:0]   rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]   rs2_o,
    output logic                            hazard_o,
    output rv_pkg::dec_exe_t                exe_o
);

    logic [rv_pkg::XLEN-1:0] word;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic                    uses_rs1;
    logic                    uses_rs2;
    logic                    exe_writes;
    rv_pkg::op_e             op;
    rv_pkg::dec_exe_t        exe_q;

    assign word = instruction_i;

    ////////////////////
    // immediates
    ////////////////////
    assign imm_i = {{20{instruction_i.i.imm[11]}}, instruction_i.i.imm};
    assign imm_s = {{20{instruction_i.s.imm_hi[6]}}, instruction_i.s.imm_hi,
                    instruction_i.s.imm_lo};
    // B layout scattered over the S fields
    assign imm_b = {{19{instruction_i.s.imm_hi[6]}}, instruction_i.s.imm_hi[6],
                    instruction_i.s.imm_lo[0], instruction_i.s.imm_hi[5:0],
                    instruction_i.s.imm_lo[4:1], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    ////////////////////
    // opcode decode
    ////////////////////
    always_comb begin
        op       = rv_pkg::NOP;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = '0;
        case (instruction_i.r.opcode)
            rv_pkg::OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (instruction_i.r.funct3)
                    3'b000: begin
                        if (instruction_i.r.funct7 == 7'b0000000) begin
                            op = rv_pkg::ADD;
                        end else if (instruction_i.r.funct7 == 7'b0100000) begin
                            op = rv_pkg::SUB;
                        end
                    end
                    3'b100: op = rv_pkg::XOR;
                    3'b110: op = rv_pkg::OR;
                    3'b111: op = rv_pkg::AND;
                    default: op = rv_pkg::NOP;
                endcase
            end
            rv_pkg::OPC_OPIMM: begin
                uses_rs1 = 1'b1;
                imm      = imm_i;
                // only addi is kept
                if (instruction_i.i.funct3 == 3'b000) begin
                    op = rv_pkg::ADD;
                end
            end
            rv_pkg::OPC_LUI: begin
                imm = imm_u;
                op  = rv_pkg::LUI;
            end
            rv_pkg::OPC_LOAD: begin
                uses_rs1 = 1'b1;
                imm      = imm_i;
                if (instruction_i.i.funct3 == 3'b010) begin
                    op = rv_pkg::LW;
                end
            end
            rv_pkg::OPC_STORE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_s;
                if (instruction_i.s.funct3 == 3'b010) begin
                    op = rv_pkg::SW;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                if (instruction_i.s.funct3 == 3'b000) begin
                    op = rv_pkg::BEQ;
                end else if (instruction_i.s.funct3 == 3'b001) begin
                    op = rv_pkg::BNE;
                end
            end
            rv_pkg::OPC_JAL: begin
                imm = imm_j;
                op  = rv_pkg::JAL;
            end
            default: op = rv_pkg::NOP;
        endcase
    end

    ////////////////////
    // operands, hazard
    ////////////////////
    assign rs1_o = instruction_i.r.rs1;
    assign rs2_o = instruction_i.r.rs2;

    // retiring result beats the bank, write lands at end of cycle
    assign rs1_val = (wb_i.we && wb_i.rd == rs1_o) ? wb_i.result : rs1_data_i;
    assign rs2_val = (wb_i.we && wb_i.rd == rs2_o) ? wb_i.result : rs2_data_i;

    // producer still in execute, wait until it retires
    assign exe_writes = exe_i.valid && rv_pkg::writes_rd(exe_i.op) && exe_i.rd != '0;
    assign hazard_o   = exe_writes && ((uses_rs1 && rs1_o == exe_i.rd) ||
                                       (uses_rs2 && rs2_o == exe_i.rd));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_q <= '0;
        end else if (!stall_i) begin
            // bubble on hazard, drop the word under a jump
            exe_q.valid <= !hazard_o && !redirect_i.valid;
            exe_q.op    <= op;
            exe_q.rd    <= instruction_i.r.rd;
            exe_q.a     <= rs1_val;
            // addi takes its immediate as second operand
            exe_q.b     <= (instruction_i.r.opcode == rv_pkg::OPC_OPIMM) ? imm : rs2_val;
            exe_q.imm   <= imm;
            exe_q.pc    <= pc_i;
            exe_q.tag   <= tag_i;
        end
    end

    assign exe_o = exe_q;

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        stall_i,
    input  rv_pkg::dec_exe_t            exe_i,
    input  logic [rv_pkg::XLEN-1:0]     mem_data_i,
    output rv_pkg::redirect_t           redirect_o,
    output rv_pkg::wb_t                 wb_o,
    output logic                        mem_operation_enable_o,
    output logic [3:0]                  mem_write_enable_o,
    output logic [rv_pkg::XLEN-1:0]     mem_address_o,
    output logic [rv_pkg::XLEN-1:0]     mem_data_o
);

    logic [rv_pkg::TAG_W-1:0] tag_q;
    logic [rv_pkg::XLEN-1:0]  result;
    logic                     take;
    logic                     live;
    logic                     fire;
    logic                     load_req;
    logic                     store_req;
    rv_pkg::wb_t              wb_q;

    // stale tag means wrong path, treat as nop
    assign live = exe_i.valid && exe_i.tag == tag_q;
    assign fire = live && !stall_i;

    ////////////////////
    // alu and branch
    ////////////////////
    always_comb begin
        result = '0;
        take   = 1'b0;
        case (exe_i.op)
            rv_pkg::ADD: result = exe_i.a + exe_i.b;
            rv_pkg::SUB: result = exe_i.a - exe_i.b;
            rv_pkg::AND: result = exe_i.a & exe_i.b;
            rv_pkg::OR:  result = exe_i.a | exe_i.b;
            rv_pkg::XOR: result = exe_i.a ^ exe_i.b;
            rv_pkg::LUI: result = exe_i.imm;
            rv_pkg::BEQ: take = exe_i.a == exe_i.b;
            rv_pkg::BNE: take = exe_i.a != exe_i.b;
            rv_pkg::JAL: begin
                // link value
                result = exe_i.pc + rv_pkg::XLEN'(4);
                take   = 1'b1;
            end
            default: result = '0;
        endcase
    end

    assign redirect_o.valid  = fire && take;
    assign redirect_o.target = exe_i.pc + exe_i.imm;

    ////////////////////
    // data memory
    ////////////////////
    assign load_req  = live && exe_i.op == rv_pkg::LW;
    assign store_req = live && exe_i.op == rv_pkg::SW;

    // address and data hold through a stall, the enables do not
    assign mem_address_o          = exe_i.a + exe_i.imm;
    assign mem_data_o             = exe_i.b;
    assign mem_write_enable_o     = {4{store_req && !stall_i}};
    assign mem_operation_enable_o = (load_req || store_req) && !stall_i;

    ////////////////////
    // retire
    ////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tag_q <= '0;
            wb_q  <= '0;
        end else begin
            // follows the fetch tag, one step per jump
            if (fire && take) begin
                tag_q <= tag_q + 1'b1;
            end
            wb_q.we      <= fire && rv_pkg::writes_rd(exe_i.op) && exe_i.rd != '0;
            wb_q.rd      <= exe_i.rd;
            wb_q.result  <= result;
            wb_q.is_load <= exe_i.op == rv_pkg::LW;
        end
    end

    // loads pick up memory data so decode forwards the right value
    always_comb begin
        wb_o = wb_q;
        if (wb_q.is_load) begin
            wb_o.result = mem_data_i;
        end
    end

    // never a store strobe alongside a load
    a_store_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_write_enable_o != '0 |-> !load_req);

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        stall_i,
    input  logic [rv_pkg::XLEN-1:0]     instruction_i,
    input  logic [rv_pkg::XLEN-1:0]     mem_data_i,
    output logic [rv_pkg::XLEN-1:0]     instruction_address_o,
    output logic                        mem_operation_enable_o,
    output logic [3:0]                  mem_write_enable_o,
    output logic [rv_pkg::XLEN-1:0]     mem_address_o,
    output logic [rv_pkg::XLEN-1:0]     mem_data_o
);

    ////////////////////
    // stage links
    ////////////////////
    rv_pkg::instr_u                   instr;
    logic [rv_pkg::XLEN-1:0]          pc;
    logic [rv_pkg::TAG_W-1:0]         tag;
    logic [rv_pkg::REG_ADDR_W-1:0]    rs1;
    logic [rv_pkg::REG_ADDR_W-1:0]    rs2;
    logic [rv_pkg::XLEN-1:0]          rs1_data;
    logic [rv_pkg::XLEN-1:0]          rs2_data;
    logic                             hazard;
    logic                             enable_fetch;
    rv_pkg::dec_exe_t                 exe;
    rv_pkg::wb_t                      wb;
    rv_pkg::redirect_t                redirect;

    // fetch freezes with the rest of the pipe or behind a hazard
    assign enable_fetch = !(stall_i || hazard);

    rv_fetch u_fetch (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .enable_i               (enable_fetch),
        .redirect_i             (redirect),
        .instruction_data_i     (instruction_i),
        .instruction_address_o  (instruction_address_o),
        .instruction_o          (instr),
        .pc_o                   (pc),
        .tag_o                  (tag)
    );

    // exe is also fed back for the hazard check
    rv_decode u_decode (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .instruction_i  (instr),
        .pc_i           (pc),
        .tag_i          (tag),
        .redirect_i     (redirect),
        .exe_i          (exe),
        .wb_i           (wb),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .hazard_o       (hazard),
        .exe_o          (exe)
    );

    rv_regbank u_regbank (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .wb_i           (wb),
        .mem_data_i     (mem_data_i),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data)
    );

    rv_execute u_execute (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .stall_i                (stall_i),
        .exe_i                  (exe),
        .mem_data_i             (mem_data_i),
        .redirect_o             (redirect),
        .wb_o                   (wb),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

endmodule

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    // tests take a few hundred cycles together, stalls included
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] MARKER = 32'h0000_00fc;
    // only ever built on a wrong path
    localparam logic [31:0] POISON = 32'h0bad_0666;

    logic        clk;
    logic        arst_n_i;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_mem [64];
    // final memory of the unstalled load/store run
    logic [31:0] ref_mem [64];
    logic [15:0] lfsr;
    logic        stall_en;
    logic        marker_seen;
    int          ip;
    int          cycle_cnt;
    int          mismatch_errs;
    int          other_errs;

    rv_core u_dut (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // encoders
    ////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rr_word(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                            int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(int rs2, int rs1, int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
    endfunction

    // f3 000 beq, 001 bne
    function automatic logic [31:0] branch_word(logic [2:0] f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(int rd, logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    ////////////////////
    // memories
    ////////////////////
    // both answer one cycle late, driven 1 ns after the edge
    always @(posedge clk) begin
        logic [31:0] next_instr;
        logic [31:0] next_rdata;
        logic        next_stall;
        next_instr = imem[instruction_address_o[7:2]];
        next_rdata = mem_data_i;
        next_stall = 1'b0;
        cycle_cnt++;
        // no access may go out while the pipe is frozen
        if (mem_operation_enable_o) begin
            assert (!stall_i) else begin
                $display("memory access enabled while stall_i was high");
                other_errs++;
            end
        end
        if (mem_write_enable_o != 4'b0000) begin
            assert (!stall_i) else begin
                $display("store issued while stall_i was high");
                other_errs++;
            end
            assert (mem_operation_enable_o && mem_write_enable_o == 4'hf &&
                    mem_address_o[1:0] == 2'b00) else begin
                $display("store without a full word strobe or with an unaligned address");
                other_errs++;
            end
            assert (mem_data_o != POISON) else begin
                $display("wrong-path store reached memory at address %08h", mem_address_o);
                other_errs++;
            end
            dmem[mem_address_o[7:2]] = mem_data_o;
            marker_seen = marker_seen || mem_address_o == MARKER;
        end else if (mem_operation_enable_o) begin
            next_rdata = dmem[mem_address_o[7:2]];
        end
        // one lfsr step per stall bit
        if (stall_en) begin
            lfsr       = lfsr_step(lfsr);
            next_stall = lfsr[0];
        end
        #1;
        instruction_i = next_instr;
        mem_data_i    = next_rdata;
        stall_i       = next_stall;
    end

    ////////////////////
    // test helpers
    ////////////////////
    task automatic put(logic [31:0] word);
        imem[ip] = word;
        ip++;
    endtask

    task automatic expect_word(logic [31:0] addr, logic [31:0] value);
        exp_mem[addr[7:2]] = value;
    endtask

    // reset held from here, program goes in behind it
    task automatic begin_program();
        @(posedge clk);
        #1;
        arst_n_i    = 1'b0;
        stall_en    = 1'b0;
        marker_seen = 1'b0;
        ip          = 0;
        for (int i = 0; i < 64; i++) begin
            // filler is addi x0, x0, i
            imem[i]    = addi_word(0, 0, i);
            dmem[i]    = 32'hd000_0000 ^ (32'(i) * 32'h0104_0811);
            exp_mem[i] = dmem[i];
        end
    endtask

    // marker store then a self loop
    task automatic run_program(logic with_stall);
        put(sw_word(0, 0, MARKER));
        put(jal_word(0, 0));
        repeat (2) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        stall_en = with_stall;
        wait (marker_seen);
        stall_en = 1'b0;
        expect_word(MARKER, 32'h0);
    endtask

    task automatic check_memory(string name);
        for (int i = 0; i < 64; i++) begin
            assert (dmem[i] == exp_mem[i]) else begin
                $display("Mismatch dmem[0x%h] (%s): expected %08h, got %08h",
                         8'(i * 4), name, exp_mem[i], dmem[i]);
                mismatch_errs++;
            end
        end
    endtask

    task automatic report();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] u;
        a = 32'h0000_0123;
        b = -32'sh456;
        u = 32'h1234_5000;
        begin_program();
        put(addi_word(1, 0, a));
        put(addi_word(2, 0, b));
        put(lui_word(3, u[31:12]));
        put(rr_word(7'h00, 3'b000, 4, 1, 2));
        put(rr_word(7'h20, 3'b000, 5, 1, 2));
        put(rr_word(7'h00, 3'b111, 6, 3, 2));
        put(rr_word(7'h00, 3'b110, 7, 3, 1));
        put(rr_word(7'h00, 3'b100, 8, 3, 2));
        // x1..x8 to words 0..7
        for (int r = 1; r <= 8; r++) begin
            put(sw_word(r, 0, 4 * (r - 1)));
        end
        run_program(1'b0);
        expect_word('h00, a);
        expect_word('h04, b);
        expect_word('h08, u);
        expect_word('h0c, a + b);
        expect_word('h10, a - b);
        expect_word('h14, u & b);
        expect_word('h18, u | a);
        expect_word('h1c, u ^ b);
        check_memory("alu");
    endtask

    task automatic x0_and_forwarding();
        logic [31:0] v;
        logic [31:0] w;
        begin_program();
        put(addi_word(0, 0, 5));
        put(lui_word(0, 20'hfffff));
        // every step reads the result just made
        put(addi_word(1, 0, 1));
        put(addi_word(1, 1, 2));
        put(rr_word(7'h00, 3'b000, 2, 1, 1));
        put(rr_word(7'h00, 3'b000, 2, 2, 1));
        put(rr_word(7'h00, 3'b100, 2, 2, 1));
        put(rr_word(7'h20, 3'b000, 3, 2, 0));
        put(sw_word(0, 0, 'h00));
        put(sw_word(2, 0, 'h04));
        put(sw_word(3, 0, 'h08));
        run_program(1'b0);
        v = 32'd1 + 32'd2;
        w = ((v + v) + v) ^ v;
        expect_word('h00, 32'h0);
        expect_word('h04, w);
        expect_word('h08, w);
        check_memory("x0 and forwarding");
    endtask

    task automatic load_store(logic with_stall);
        logic [31:0] c;
        c = 32'hcafe_0123;
        begin_program();
        put(lui_word(1, c[31:12]));
        put(addi_word(1, 1, c[11:0]));
        put(sw_word(1, 0, 'h20));
        put(lw_word(2, 0, 'h20));
        // load-use into alu and into store data
        put(addi_word(3, 2, 1));
        put(sw_word(3, 0, 'h24));
        put(sw_word(2, 0, 'h28));
        put(lw_word(4, 0, 'h30));
        put(sw_word(4, 0, 'h2c));
        run_program(with_stall);
        expect_word('h20, c);
        expect_word('h24, c + 1);
        expect_word('h28, c);
        expect_word('h2c, exp_mem['h30 >> 2]);
        check_memory(with_stall ? "load/store stalled" : "load/store");
    endtask

    task automatic jumps_and_squash();
        logic [31:0] link;
        begin_program();
        put(addi_word(1, 0, 7));
        put(addi_word(2, 0, 7));
        put(lui_word(31, POISON[31:12]));
        put(addi_word(31, 31, POISON[11:0]));
        // beq taken over two poison stores
        put(branch_word(3'b000, 1, 2, 12));
        put(sw_word(31, 0, 'h40));
        put(sw_word(31, 0, 'h44));
        // bne not taken
        put(branch_word(3'b001, 1, 2, 8));
        put(addi_word(3, 0, 'h11));
        link = 32'(ip * 4 + 4);
        put(jal_word(5, 12));
        put(sw_word(31, 0, 'h48));
        put(sw_word(31, 0, 'h4c));
        // bne taken, then beq not taken
        put(branch_word(3'b001, 1, 0, 8));
        put(sw_word(31, 0, 'h50));
        put(branch_word(3'b000, 1, 0, 8));
        put(addi_word(3, 3, 'h22));
        put(sw_word(3, 0, 'h54));
        put(sw_word(5, 0, 'h58));
        run_program(1'b0);
        expect_word('h54, 32'h11 + 32'h22);
        expect_word('h58, link);
        check_memory("jumps");
    endtask

    task automatic random_stall();
        load_store(1'b1);
        exp_mem = ref_mem;
        check_memory("stalled against unstalled run");
    endtask

    ////////////////////
    // sequence
    ////////////////////
    initial begin
        arst_n_i      = 1'b0;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        stall_en      = 1'b0;
        marker_seen   = 1'b0;
        lfsr          = 16'd99;
        cycle_cnt     = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        alu_ops();
        x0_and_forwarding();
        load_store(1'b0);
        ref_mem = dmem;
        jumps_and_squash();
        random_stall();
        report();
    end

    // stuck program or a lost marker store
    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: no marker store within %0d cycles", TIMEOUT_CYCLES);
        other_errs++;
        report();
    end

endmodule

//--- src.f
logic/rv_pkg.sv
logic/rv_regbank.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_core.sv
verification/tb_rv_core.sv

//--- Makefile
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_rv_core: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f src.f

run: obj_dir/Vtb_rv_core
	@out="$$(./obj_dir/Vtb_rv_core)"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir
